/* Makefile */
# Verilator build and run of the pipeline trace unit testbench

VERILATOR  ?= verilator
FLIST      := flist.f
TOP        := pipe_trace_tb
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# Exit status comes from the search for the pass line
run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

/* flist.f */
rtl/trace_cfg_pkg.sv
rtl/trace_types_pkg.sv
rtl/stage_tagger.sv
rtl/trace_store.sv
rtl/retire_reporter.sv
rtl/pipe_trace_top.sv
sim/pipe_trace_tb.sv

/* rtl/pipe_trace_top.sv */
/* Trace unit top. Stage words, stall and hlt are plain levels sampled each edge;
   retire_valid pulses one cycle per retired instruction */

`timescale 1ns/1ps

module pipe_trace_top
    import trace_cfg_pkg::*;
    import trace_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  stage_words_t stage_words,
    input  logic         stall,
    input  logic         hlt,
    output logic         retire_valid,
    output retire_rec_t  retire
);

    stage_tag_t        fetch_tag, decode_tag, exec_tag, mem_tag, wb_tag;
    trace_rec_t        wb_rec;   // Stored record of the wb instruction
    logic [slot_w-1:0] wb_slot;

    assign wb_slot = wb_tag.id[slot_w-1:0];

    //////////////////////////////////////////////////
    // Id tracking, record store, retire output
    //////////////////////////////////////////////////
    stage_tagger u_stage_tagger (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .hlt        (hlt),
        .fetch_tag  (fetch_tag),
        .decode_tag (decode_tag),
        .exec_tag   (exec_tag),
        .mem_tag    (mem_tag),
        .wb_tag     (wb_tag)
    );

    trace_store u_trace_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .fetch_tag  (fetch_tag),
        .decode_tag (decode_tag),
        .exec_tag   (exec_tag),
        .mem_tag    (mem_tag),
        .words      (stage_words),
        .rd_slot    (wb_slot),
        .rd_rec     (wb_rec)
    );

    retire_reporter u_retire_reporter (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_tag       (wb_tag),
        .wb_word      (stage_words.wb_word),
        .rec          (wb_rec),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule : pipe_trace_top

/* rtl/retire_reporter.sv */
/* Builds the retire record from the stored fields and the live wb word, one strobe per
   valid wb cycle. No back-pressure, every strobe is taken */

`timescale 1ns/1ps

module retire_reporter
    import trace_cfg_pkg::*;
    import trace_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  stage_tag_t        wb_tag,
    input  logic [word_w-1:0] wb_word,       // Live write-back trace word
    input  trace_rec_t        rec,           // Record at the wb slot
    output logic              retire_valid,  // One cycle per instruction
    output retire_rec_t       retire
);

    instr_u            instr;     // Instruction as decoded in decode
    logic              imm_fmt;   // Opcode bit 15 picks i format
    logic [word_w-1:0] src_opnd;
    retire_rec_t       retire_nxt;

    //////////////////////////////////////////////////
    // Source operand
    //////////////////////////////////////////////////
    assign instr   = rec.instr;
    assign imm_fmt = instr.i_fmt.opcode[opc_w-1];  // Same bit in both views

    always_comb begin
        if (imm_fmt) begin
            src_opnd = word_w'(instr.i_fmt.imm8);  // Zero extended immediate
        end else begin
            src_opnd = word_w'(instr.r_fmt.rs);    // Zero extended rs index
        end
    end

    //////////////////////////////////////////////////
    // Record merge and output register
    //////////////////////////////////////////////////
    always_comb begin
        retire_nxt           = '0;
        retire_nxt.id        = rec.id;
        retire_nxt.pc        = rec.pc;
        retire_nxt.instr     = instr;
        retire_nxt.src_opnd  = src_opnd;
        retire_nxt.exec_word = rec.exec_word;
        retire_nxt.mem_word  = rec.mem_word;
        retire_nxt.wb_word   = wb_word;        // Not stored, taken as it passes
        retire_nxt.stall_cnt = rec.stall_cnt;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wb_tag.valid;  // Strobe one edge after wb
        end
    end

    // Payload only, loaded when there is something to retire
    always_ff @(posedge clk) begin
        if (wb_tag.valid) begin
            retire <= retire_nxt;
        end
    end

    // Slot read in the store must hold this instruction, not an older id
    a_rec_matches_wb : assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_tag.valid |-> (rec.id == wb_tag.id)
    ) else $error("record id %0h at wb id %0h", rec.id, wb_tag.id);

endmodule : retire_reporter

/* rtl/stage_tagger.sv */
/* Follows sequence ids through fetch, decode, execute, memory and write-back. A stall holds
   fetch and decode and bubbles execute. hlt is sticky until reset and lets the pipe drain */

`timescale 1ns/1ps

module stage_tagger
    import trace_cfg_pkg::*;
    import trace_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,      // Freeze fetch and decode
    input  logic       hlt,        // Stop new fetches
    output stage_tag_t fetch_tag,
    output stage_tag_t decode_tag,
    output stage_tag_t exec_tag,
    output stage_tag_t mem_tag,
    output stage_tag_t wb_tag
);

    logic [id_w-1:0] next_id;   // Id given to the next fetch
    logic            halted;    // Set by hlt, cleared only by reset
    logic            fetch_en;  // A new instruction may enter fetch

    // hlt acts in the edge where it is first seen
    assign fetch_en = !(halted || hlt);

    //////////////////////////////////////////////////
    // Tag pipeline
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_tag  <= '0;
            decode_tag <= '0;
            exec_tag   <= '0;
            mem_tag    <= '0;
            wb_tag     <= '0;
            next_id    <= '0;
            halted     <= 1'b0;
        end else begin
            halted  <= halted | hlt;
            mem_tag <= exec_tag;  // Back half never stalls
            wb_tag  <= mem_tag;
            if (stall) begin
                // Fetch and decode hold their tags
                exec_tag.valid <= 1'b0;  // Bubble into execute
                if (hlt) begin
                    fetch_tag.valid <= 1'b0;  // Stalled fetch never left, drop it
                end
            end else begin
                exec_tag        <= decode_tag;
                decode_tag      <= fetch_tag;   // Fetched this edge
                fetch_tag.valid <= fetch_en;
                fetch_tag.id    <= next_id;
                if (fetch_en) begin
                    next_id <= next_id + 1'b1;  // Wraps, slots reuse low bits
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Retire order check
    //////////////////////////////////////////////////
    logic [id_w-1:0] last_wb_id;  // Id of the previous valid wb
    logic            wb_seen;     // At least one wb since reset

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_seen <= 1'b0;
        end else if (wb_tag.valid) begin
            wb_seen <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_tag.valid) begin
            last_wb_id <= wb_tag.id;
        end
    end

    // Bubbles may sit between them, but no id is lost or doubled on the way down
    a_wb_ids_in_order : assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_tag.valid && wb_seen) |-> (wb_tag.id == id_w'(last_wb_id + 1'b1))
    ) else $error("wb id %0h does not follow %0h", wb_tag.id, last_wb_id);

endmodule : stage_tagger

/* rtl/trace_cfg_pkg.sv */
/* Size constants for the pipeline trace unit. slot_w must cover store_depth, and the store
   must be deeper than the five stages in flight so that live slots never alias */

package trace_cfg_pkg;

    //////////////////////////////////////////////////
    // Sequence ids and record slots
    //////////////////////////////////////////////////
    localparam int id_w        = 8;                   // Instruction sequence id
    localparam int store_depth = 16;                  // Record slots in the store
    localparam int slot_w      = $clog2(store_depth); // Slot = low bits of the id

    //////////////////////////////////////////////////
    // Stage words and instruction fields
    //////////////////////////////////////////////////
    localparam int word_w = 16; // Every stage trace word
    localparam int opc_w  = 4;  // Opcode field, top of the instruction
    localparam int reg_w  = 4;  // Register index fields rd, rs, rt
    localparam int imm_w  = 8;  // Immediate field of the i format

    // Saturating stall counter, stops at all ones
    localparam int stall_w   = 3;
    localparam int stall_max = (1 << stall_w) - 1;

endpackage : trace_cfg_pkg

/* rtl/trace_store.sv */
/* Record memory indexed by the low id bits, each field written as its stage is valid.
   Read is asynchronous. Stall counts saturate at stall_max */

`timescale 1ns/1ps

module trace_store
    import trace_cfg_pkg::*;
    import trace_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  stage_tag_t        fetch_tag,
    input  stage_tag_t        decode_tag,
    input  stage_tag_t        exec_tag,
    input  stage_tag_t        mem_tag,
    input  stage_words_t      words,
    input  logic [slot_w-1:0] rd_slot,   // Slot of the wb id
    output trace_rec_t        rd_rec
);

    trace_rec_t rec_mem [store_depth];  // One record per id in flight

    logic [slot_w-1:0]  fetch_slot, decode_slot, exec_slot, mem_slot;
    logic [stall_w-1:0] fetch_cnt;   // Stalls seen by the fetch instruction
    logic [stall_w-1:0] decode_cnt;  // Stalls seen by the decode instruction
    logic [stall_w-1:0] decode_cnt_nxt;

    function automatic logic [stall_w-1:0] sat_inc(input logic [stall_w-1:0] cnt);
        return (cnt == stall_w'(stall_max)) ? cnt : cnt + 1'b1;
    endfunction

    assign fetch_slot  = fetch_tag.id[slot_w-1:0];
    assign decode_slot = decode_tag.id[slot_w-1:0];
    assign exec_slot   = exec_tag.id[slot_w-1:0];
    assign mem_slot    = mem_tag.id[slot_w-1:0];

    //////////////////////////////////////////////////
    // Stall counters, they move with the instruction
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_cnt  <= '0;
            decode_cnt <= '0;
        end else if (stall) begin
            if (fetch_tag.valid) fetch_cnt <= sat_inc(fetch_cnt);
            if (decode_tag.valid) decode_cnt <= sat_inc(decode_cnt);
        end else begin
            decode_cnt <= fetch_cnt;  // Fetch instruction moves to decode
            fetch_cnt  <= '0;         // Fresh count for the new fetch
        end
    end

    // Count including this edge, last decode write leaves the final value
    assign decode_cnt_nxt = stall ? sat_inc(decode_cnt) : decode_cnt;

    //////////////////////////////////////////////////
    // Field writes, one slot per stage
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (fetch_tag.valid) begin
            rec_mem[fetch_slot].id <= fetch_tag.id;
            rec_mem[fetch_slot].pc <= words.fetch_word;
        end
        if (decode_tag.valid) begin
            rec_mem[decode_slot].instr     <= words.decode_word;
            rec_mem[decode_slot].stall_cnt <= decode_cnt_nxt;
        end
        if (exec_tag.valid) rec_mem[exec_slot].exec_word <= words.exec_word;
        if (mem_tag.valid) rec_mem[mem_slot].mem_word <= words.mem_word;  // Ready in wb
    end

    assign rd_rec = rec_mem[rd_slot];

    // wb is mem one edge later in the tagger, so past mem valid means wb holds
    // the instruction read through rd_slot
    a_no_fetch_over_wb : assert property (
        @(posedge clk) disable iff (!rst_n)
        (fetch_tag.valid && $past(mem_tag.valid)) |-> (fetch_slot != rd_slot)
    ) else $error("fetch write hits wb slot %0h", rd_slot);

endmodule : trace_store

/* rtl/trace_types_pkg.sv */
/* Bundles passed between the tagger, the store and the reporter. The instruction word
   decodes as register or immediate format, picked by opcode bit 15 */

package trace_types_pkg;

    import trace_cfg_pkg::*;

    //////////////////////////////////////////////////
    // Instruction word, two views of the same bits
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [opc_w-1:0] opcode; // Bits 15..12
        logic [reg_w-1:0] rd;     // Bits 11..8
        logic [reg_w-1:0] rs;     // Bits 7..4
        logic [reg_w-1:0] rt;     // Bits 3..0
    } r_fmt_t;

    typedef struct packed {
        logic [opc_w-1:0] opcode; // Same place as in r_fmt
        logic [reg_w-1:0] rd;
        logic [imm_w-1:0] imm8;   // Bits 7..0
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt; // Opcode bit 15 clear
        i_fmt_t i_fmt; // Opcode bit 15 set
    } instr_u;

    // Valid flag and id of whatever sits in one stage
    typedef struct packed {
        logic            valid;
        logic [id_w-1:0] id;
    } stage_tag_t;

    //////////////////////////////////////////////////
    // Trace words in, records stored and retired
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [word_w-1:0] fetch_word;  // Fetch pc
        instr_u            decode_word; // Instruction seen in decode
        logic [word_w-1:0] exec_word;
        logic [word_w-1:0] mem_word;
        logic [word_w-1:0] wb_word;
    } stage_words_t;

    typedef struct packed {
        logic [id_w-1:0]    id;
        logic [word_w-1:0]  pc;
        instr_u             instr;
        logic [word_w-1:0]  exec_word;
        logic [word_w-1:0]  mem_word;
        logic [stall_w-1:0] stall_cnt;
    } trace_rec_t;

    typedef struct packed {
        logic [id_w-1:0]    id;
        logic [word_w-1:0]  pc;
        instr_u             instr;
        logic [word_w-1:0]  src_opnd;  // rs or imm8, zero extended
        logic [word_w-1:0]  exec_word;
        logic [word_w-1:0]  mem_word;
        logic [word_w-1:0]  wb_word;   // Taken live from write-back
        logic [stall_w-1:0] stall_cnt;
    } retire_rec_t;

endpackage : trace_types_pkg

/* sim/pipe_trace_tb.sv */
/* Drives twelve table entries through the trace unit and checks every retire record.
   Stage timing follows a shadow pipeline, and bubble stages carry LFSR filler words */

`timescale 1ns/1ps

module pipe_trace_tb
    import trace_cfg_pkg::*;
    import trace_types_pkg::*;
();

    localparam int n_entries   = 12;
    localparam int half_period = 4;  // 8 ns clock

    typedef struct packed {
        logic [word_w-1:0] pc;
        logic [word_w-1:0] instr;
        logic [word_w-1:0] exec_w;
        logic [word_w-1:0] mem_w;
        logic [word_w-1:0] wb_w;
        logic [3:0]        stalls;  // Stall cycles raised while in decode
    } entry_t;

    typedef struct packed {
        retire_rec_t rec;
        logic [31:0] at_edge;  // Edge after reset that raises retire_valid
    } expect_t;

    logic         clk;
    logic         rst_n;
    stage_words_t stage_words;
    logic         stall;
    logic         hlt;
    logic         retire_valid;
    retire_rec_t  retire;

    entry_t       tab [n_entries];
    expect_t      exp_q [$];    // Records still to retire in id order
    expect_t      exp_cur;
    logic [31:0]  lfsr_state;
    int           err_cnt;
    int           check_cnt;
    int           edge_cnt;     // Rising edges since reset release

    // Shadow pipeline holds the table index per stage or -1 when empty
    int           f_idx;
    int           d_idx;
    int           e_idx;
    int           m_idx;
    int           w_idx;
    int           next_fetch;
    int           stall_left;   // Stalls still owed to the decode entry
    logic         stall_v;
    logic         hlt_v;
    logic         halted;
    stage_words_t words_v;

    pipe_trace_top u_pipe_trace_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .stage_words  (stage_words),
        .stall        (stall),
        .hlt          (hlt),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #half_period clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    function automatic logic [word_w-1:0] filler_word();
        logic [word_w-1:0] w;
        int                b;
        w = '0;
        for (b = 0; b < word_w; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[word_w-2:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // Bit 15 set means immediate format
    function automatic logic [word_w-1:0] operand_of(input logic [word_w-1:0] instr);
        if (instr[15]) begin
            return {8'h00, instr[7:0]};   // imm8
        end
        return {12'h000, instr[7:4]};     // rs
    endfunction

    function automatic int stall_sum();
        int i;
        int s;
        s = 0;
        for (i = 0; i < n_entries; i++) begin
            s += int'(tab[i].stalls);
        end
        return s;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        check_cnt++;
        assert (act_v === exp_v) else begin
            err_cnt++;
            $display("CHECK FAILED %s expected %0h actual %0h at %0t", name, exp_v, act_v,
                     $time);
        end
    endtask

    //////////////////////////////////////////////////
    // Shadow pipeline and stimulus
    //////////////////////////////////////////////////
    task automatic advance_shadow();
        edge_cnt++;
        w_idx = m_idx;  // Back half always moves
        m_idx = e_idx;
        if (stall_v) begin
            e_idx = -1;  // Bubble into execute
            if (hlt_v) begin
                f_idx = -1;
            end
            stall_left--;
        end else begin
            e_idx = d_idx;
            d_idx = f_idx;
            if (halted || hlt_v) begin
                f_idx = -1;
            end else begin
                f_idx = next_fetch;
                next_fetch++;
            end
            if (d_idx >= 0) begin
                stall_left = int'(tab[d_idx].stalls);  // New decode entry
            end
        end
        halted = halted || hlt_v;
    endtask

    task automatic drive_inputs();
        stall_v = (d_idx >= 0) && (stall_left > 0);
        // hlt pulses for the one free edge on which the last entry leaves fetch
        hlt_v = (f_idx == n_entries - 1) && !stall_v;
        if (f_idx >= 0) words_v.fetch_word = tab[f_idx].pc;
        else words_v.fetch_word = filler_word();
        if (d_idx >= 0) words_v.decode_word = tab[d_idx].instr;
        else words_v.decode_word = filler_word();
        if (e_idx >= 0) words_v.exec_word = tab[e_idx].exec_w;
        else words_v.exec_word = filler_word();
        if (m_idx >= 0) words_v.mem_word = tab[m_idx].mem_w;
        else words_v.mem_word = filler_word();
        if (w_idx >= 0) words_v.wb_word = tab[w_idx].wb_w;
        else words_v.wb_word = filler_word();
        stall       <= stall_v;
        hlt         <= hlt_v;
        stage_words <= words_v;
    endtask

    initial begin
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            advance_shadow();
            drive_inputs();
        end
    end

    //////////////////////////////////////////////////
    // Retire checks sampled mid cycle
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            assert (exp_q.size() != 0) else begin
                err_cnt++;
                $display("Retire strobe at edge %0d with every record already retired",
                         edge_cnt);
            end
            if (exp_q.size() != 0) begin
                exp_cur = exp_q.pop_front();
                check_field("retire_edge", exp_cur.at_edge, edge_cnt);
                check_field("id", 32'(exp_cur.rec.id), 32'(retire.id));
                check_field("pc", 32'(exp_cur.rec.pc), 32'(retire.pc));
                check_field("instr", 32'(exp_cur.rec.instr), 32'(retire.instr));
                check_field("src_opnd", 32'(exp_cur.rec.src_opnd), 32'(retire.src_opnd));
                check_field("exec_word", 32'(exp_cur.rec.exec_word), 32'(retire.exec_word));
                check_field("mem_word", 32'(exp_cur.rec.mem_word), 32'(retire.mem_word));
                check_field("wb_word", 32'(exp_cur.rec.wb_word), 32'(retire.wb_word));
                check_field("stall_cnt", 32'(exp_cur.rec.stall_cnt), 32'(retire.stall_cnt));
            end
        end
    end

    // Watchdog sized from the table
    initial begin
        wait (rst_n === 1'b1);
        repeat (n_entries + stall_sum() + 20) @(posedge clk);
        err_cnt++;
        $display("Timeout with %0d records never retired after %0d cycles", exp_q.size(),
                 edge_cnt);
        $display("Run ended: %0d checks, %0d errors", check_cnt, err_cnt);
        $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////
    // Table, expectations, run control
    //////////////////////////////////////////////////
    initial begin : main_flow
        expect_t e;
        int      i;
        int      cum;
        int      cnt;
        int      sat;
        clk         = 1'b0;
        rst_n       = 1'b0;
        stall       = 1'b0;
        hlt         = 1'b0;
        stage_words = '0;
        err_cnt     = 0;
        check_cnt   = 0;
        edge_cnt    = 0;
        lfsr_state  = 32'hd4793c14;
        f_idx       = -1;
        d_idx       = -1;
        e_idx       = -1;
        m_idx       = -1;
        w_idx       = -1;
        next_fetch  = 0;
        stall_left  = 0;
        stall_v     = 1'b0;
        hlt_v       = 1'b0;
        halted      = 1'b0;
        words_v     = '0;

        //          pc        instr     exec      mem       wb        stalls
        tab[0]  = '{16'h0100, 16'h1234, 16'h3c01, 16'h4d10, 16'h5e21, 4'd0};
        tab[1]  = '{16'h0104, 16'h9a5c, 16'h3c92, 16'h4da3, 16'h5eb4, 4'd0};
        tab[2]  = '{16'h0108, 16'h2f01, 16'h3c25, 16'h4d36, 16'h5e47, 4'd0};
        tab[3]  = '{16'h010c, 16'h8342, 16'h3cb8, 16'h4dc9, 16'h5eda, 4'd2};
        tab[4]  = '{16'h0110, 16'h4567, 16'h3c4b, 16'h4d5c, 16'h5e6d, 4'd0};
        tab[5]  = '{16'h0114, 16'hc0ff, 16'h3cde, 16'h4def, 16'h5ef0, 4'd0};
        tab[6]  = '{16'h0118, 16'h7abc, 16'h3c71, 16'h4d82, 16'h5e93, 4'd9};  // Saturates
        tab[7]  = '{16'h011c, 16'hf1e0, 16'h3c04, 16'h4d15, 16'h5e26, 4'd0};
        tab[8]  = '{16'h0120, 16'h0def, 16'h3c97, 16'h4da8, 16'h5eb9, 4'd0};
        tab[9]  = '{16'h0124, 16'ha310, 16'h3c2a, 16'h4d3b, 16'h5e4c, 4'd1};
        tab[10] = '{16'h0128, 16'h6789, 16'h3cbd, 16'h4dce, 16'h5edf, 4'd3};
        tab[11] = '{16'h012c, 16'hb2a7, 16'h3c50, 16'h4d61, 16'h5e72, 4'd2};  // Last fetch

        // Stalls of the previous entry land while this one sits in fetch
        sat = 7;  // Three bit count stops here
        cum = 0;
        for (i = 0; i < n_entries; i++) begin
            cum += int'(tab[i].stalls);
            cnt = int'(tab[i].stalls);
            if (i > 0) begin
                cnt += int'(tab[i-1].stalls);
            end
            if (cnt > sat) begin
                cnt = sat;
            end
            e               = '0;
            e.rec.id        = id_w'(i);
            e.rec.pc        = tab[i].pc;
            e.rec.instr     = tab[i].instr;
            e.rec.src_opnd  = operand_of(tab[i].instr);
            e.rec.exec_word = tab[i].exec_w;
            e.rec.mem_word  = tab[i].mem_w;
            e.rec.wb_word   = tab[i].wb_w;
            e.rec.stall_cnt = stall_w'(cnt);
            e.at_edge       = 32'(6 + i + cum);  // Fetch, four stages, strobe
            exp_q.push_back(e);
        end

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (8) @(negedge clk);  // Strobe stays low once drained
        $display("Run ended: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : pipe_trace_tb
